// ==== files.f ====
rvPkg.sv
regFile.sv
instrDecode.sv
aluExec.sv
controlUnit.sv
cpuDatapath.sv
multiCycleCpu.sv
cpu_properties.sv
cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module cpuTb -o cpuSim
status=$?
if [ $status -ne 0 ]; then
    echo "FAIL: Verilator build returned $status"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "FAIL: simulation returned $status, see sim.log"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL: pass line missing from sim.log"
exit 1

// ==== cpuTb.sv ====
`timescale 1ns/1ns

module cpuTb;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } storeRec_t;

    localparam int timeoutCycles = 2000;

    logic        clk;
    logic        reset;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic [31:0] memReadData;
    logic        memRead;
    logic        memWrite;
    logic        halted;

    logic [31:0] mem [0:255];
    logic [31:0] lfsr = 32'h4c0a_ec38;
    storeRec_t   expStores [$];   // Stores the reference model predicts, in order
    int          expCount;
    int          storeCount = 0;
    int          cycles;

    assign memReadData = mem[memAddr[9:2]];   // Combinational read

    multiCycleCpu u_multiCycleCpu (
        .clk          (clk),
        .reset        (reset),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memReadData  (memReadData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .halted       (halted)
    );

    bind multiCycleCpu cpuProperties u_cpuProperties (
        .clk      (clk),
        .reset    (reset),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted),
        .memAddr  (memAddr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [11:0] randImm12();
        logic [11:0] v;
        for (int i = 0; i < 12; i++) begin
            lfsr = lfsrStep(lfsr);
            v[i] = lfsr[0];   // One step per bit
        end
        return v;
    endfunction

    function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encAddi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encLw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] encSw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encBeq(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic buildProgram();
        logic [31:0] prog [$];
        prog.push_back(encAddi(5'd1, 5'd0, randImm12()));
        prog.push_back(encAddi(5'd2, 5'd0, randImm12()));
        prog.push_back(encAddi(5'd3, 5'd0, randImm12()));
        prog.push_back(encR(7'b0000000, 3'b000, 5'd4, 5'd1, 5'd2));   // add
        prog.push_back(encR(7'b0100000, 3'b000, 5'd5, 5'd1, 5'd3));   // sub
        prog.push_back(encR(7'b0000000, 3'b111, 5'd6, 5'd2, 5'd3));   // and
        prog.push_back(encR(7'b0000000, 3'b110, 5'd7, 5'd1, 5'd3));   // or
        prog.push_back(encSw(5'd1, 5'd0, 12'h200));
        prog.push_back(encSw(5'd4, 5'd0, 12'h204));
        prog.push_back(encSw(5'd5, 5'd0, 12'h208));
        prog.push_back(encSw(5'd6, 5'd0, 12'h20c));
        prog.push_back(encSw(5'd7, 5'd0, 12'h210));
        prog.push_back(encSw(5'd2, 5'd0, 12'h214));
        prog.push_back(encLw(5'd8, 5'd0, 12'h214));   // Round trip through memory
        prog.push_back(encSw(5'd8, 5'd0, 12'h218));
        prog.push_back(encBeq(5'd1, 5'd1, 13'd8));    // Always taken
        prog.push_back(encSw(5'd3, 5'd0, 12'h21c));
        prog.push_back(encBeq(5'd1, 5'd2, 13'd8));    // Taken only if x1 equals x2
        prog.push_back(encSw(5'd3, 5'd0, 12'h220));
        prog.push_back(encAddi(5'd0, 5'd0, randImm12()));
        prog.push_back(encSw(5'd0, 5'd0, 12'h224));
        prog.push_back(32'h0000_0073);                // ecall
        for (int i = 0; i < 256; i++) begin
            mem[i] = {16'hbad0, i[7:0], ~i[7:0]};
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i];
        end
    endtask

    // Instruction level model of the RV32I subset
    task automatic runModel();
        logic [31:0] regs [0:31];
        logic [31:0] dmem [0:255];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] ins;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        running;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        dmem = mem;
        pc = '0;
        running = 1'b1;
        steps = 0;
        while (running && steps < 1000) begin
            ins = dmem[pc[9:2]];
            rd = ins[11:7];
            rs1 = ins[19:15];
            rs2 = ins[24:20];
            nextPc = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: begin
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: regs[rd] = regs[rs1] + regs[rs2];
                        10'b0100000_000: regs[rd] = regs[rs1] - regs[rs2];
                        10'b0000000_111: regs[rd] = regs[rs1] & regs[rs2];
                        10'b0000000_110: regs[rd] = regs[rs1] | regs[rs2];
                        default: ;
                    endcase
                end
                7'b0010011: regs[rd] = regs[rs1] + {{20{ins[31]}}, ins[31:20]};
                7'b0000011: begin
                    addr = regs[rs1] + {{20{ins[31]}}, ins[31:20]};
                    regs[rd] = dmem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = regs[rs1] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    dmem[addr[9:2]] = regs[rs2];
                    expStores.push_back({addr, regs[rs2]});
                end
                7'b1100011: begin
                    if (regs[rs1] == regs[rs2]) begin
                        nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b1110011: running = 1'b0;
                default: ;
            endcase
            regs[0] = '0;
            pc = nextPc;
            steps++;
        end
        expCount = expStores.size();
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic reportStoreMismatch(storeRec_t rec);
        if (memAddr != rec.addr) begin
            abortRun($sformatf("CHECK FAILED at %0t: memAddr expected %h actual %h",
                               $time, rec.addr, memAddr));
        end else begin
            abortRun($sformatf("CHECK FAILED at %0t: memWriteData expected %h actual %h",
                               $time, rec.data, memWriteData));
        end
    endtask

    // Memory write port and store checker
    always @(posedge clk) begin
        storeRec_t rec;
        if (!reset && memWrite) begin
            mem[memAddr[9:2]] <= memWriteData;
            storeCount++;
            if (expStores.size() == 0) begin
                abortRun("A store happened after the expected sequence ended");
            end else begin
                rec = expStores.pop_front();
                assert (memAddr == rec.addr && memWriteData == rec.data)
                    else reportStoreMismatch(rec);
            end
        end
    end

    initial begin
        reset <= 1'b1;
        buildProgram();
        runModel();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!halted && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            abortRun($sformatf("Timed out after %0d cycles waiting for halted", cycles));
        end else begin
            repeat (10) @(posedge clk);   // Quiet cycles after ecall
            if (storeCount == expCount) begin
                $display("Test passed");
                $finish;
            end else begin
                abortRun($sformatf("CHECK FAILED at %0t: storeCount expected %0d actual %0d",
                                   $time, expCount, storeCount));
            end
        end
    end

endmodule

// ==== cpu_properties.sv ====
`timescale 1ns/1ns

module cpuProperties (
    input logic                   clk,
    input logic                   reset,
    input logic                   memRead,
    input logic                   memWrite,
    input logic                   halted,
    input logic [rvPkg::xlen-1:0] memAddr
);

    // One shared port, so one access per cycle
    pExclusive: assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    pHaltSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted dropped without a reset");

    pHaltQuiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> !memRead && !memWrite)
        else $error("memory strobe while halted");

    // First cycle out of reset is the fetch at address 0
    pResetFetch: assert property (@(posedge clk)
        $fell(reset) |-> memRead && !memWrite && !halted && memAddr == '0)
        else $error("first cycle after reset is not a fetch from address 0");

    pAligned: assert property (@(posedge clk) disable iff (reset)
        (memRead || memWrite) |-> memAddr[1:0] == 2'b00)
        else $error("memory access to an address that is not word aligned");

endmodule

// ==== multiCycleCpu.sv ====
`timescale 1ns/1ns

module multiCycleCpu (
    input  logic                   clk,
    input  logic                   reset,
    output logic [rvPkg::xlen-1:0] memAddr,
    output logic [rvPkg::xlen-1:0] memWriteData,
    input  logic [rvPkg::xlen-1:0] memReadData,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   halted
);
    import rvPkg::*;

    ctrlWord_t  ctrl;
    logic [6:0] opcode;

    // Strobes straight from the current microcode word
    assign memRead = ctrl.memRead;
    assign memWrite = ctrl.memWrite;

    controlUnit u_controlUnit (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .ctrl   (ctrl),
        .halted (halted)
    );

    cpuDatapath u_cpuDatapath (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .opcode       (opcode),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memReadData  (memReadData)
    );

endmodule

// ==== cpuDatapath.sv ====
`timescale 1ns/1ns

module cpuDatapath (
    input  logic                   clk,
    input  logic                   reset,
    input  rvPkg::ctrlWord_t       ctrl,
    output logic [6:0]             opcode,
    output logic [rvPkg::xlen-1:0] memAddr,
    output logic [rvPkg::xlen-1:0] memWriteData,
    input  logic [rvPkg::xlen-1:0] memReadData
);
    import rvPkg::*;

    instr_t          ir;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instrPc;   // Address of the instruction in IR
    logic [xlen-1:0] mdr;
    logic [xlen-1:0] regA;
    logic [xlen-1:0] regB;
    logic [xlen-1:0] aluOut;

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] readA;
    logic [xlen-1:0] readB;
    logic [xlen-1:0] aluPc;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] writeBack;
    logic [xlen-1:0] pcNext;
    aluOp_t          decodedOp;
    aluOp_t          aluOp;
    logic            zero;
    logic            pcEn;

    assign opcode = ir.r.opcode;
    assign memAddr = ctrl.iOrD ? aluOut : pc;
    assign memWriteData = regB;
    assign writeBack = ctrl.memToReg ? mdr : aluOut;

    // Fetch and decode always add
    assign aluOp = (ctrl.aluSrcA == srcAPc) ? aluAdd : decodedOp;
    // Live PC while fetching, then the PC the instruction came from
    assign aluPc = ctrl.irWrite ? pc : instrPc;

    assign pcNext = ctrl.pcSource ? aluOut : aluResult;
    assign pcEn = ctrl.pcWrite | (ctrl.pcWriteCond & zero);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pcEn) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            ir <= instr_t'(memReadData);
            instrPc <= pc;
        end
        mdr <= memReadData;
        regA <= readA;
        regB <= readB;
        aluOut <= aluResult;
    end

    instrDecode u_instrDecode (
        .instr (ir),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm),
        .aluOp (decodedOp)
    );

    aluExec u_aluExec (
        .pc     (aluPc),
        .regA   (regA),
        .regB   (regB),
        .imm    (imm),
        .srcA   (ctrl.aluSrcA),
        .srcB   (ctrl.aluSrcB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    regFile u_regFile (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .writeEn   (ctrl.regWrite),
        .writeData (writeBack),
        .readA     (readA),
        .readB     (readB)
    );

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic             clk,
    input  logic             reset,
    input  logic [6:0]       opcode,
    output rvPkg::ctrlWord_t ctrl,
    output logic             halted
);
    import rvPkg::*;

    typedef enum logic [1:0] {nextFixed, nextDispatchOp, nextDispatchMem} nextSel_t;

    typedef struct packed {
        ctrlWord_t ctrl;
        nextSel_t  nextSel;
        uState_t   next;
    } uEntry_t;

    uState_t state;
    uState_t dispatchOp;
    uState_t dispatchMem;
    uEntry_t entry;
    uEntry_t microRom [0:15];

    // Microcode contents, one word per state
    function automatic uEntry_t romEntry(uState_t s);
        uEntry_t e;
        e = '0;
        e.nextSel = nextFixed;
        e.next = sFetch;
        case (s)
            sFetch: begin
                e.ctrl.memRead = 1'b1;
                e.ctrl.irWrite = 1'b1;
                e.ctrl.pcWrite = 1'b1;
                e.ctrl.aluSrcA = srcAPc;
                e.ctrl.aluSrcB = srcBFour;   // PC + 4
                e.next = sDecode;
            end
            sDecode: begin
                e.ctrl.aluSrcA = srcAPc;
                e.ctrl.aluSrcB = srcBImm;    // Branch target into ALUOut
                e.nextSel = nextDispatchOp;
            end
            sRExec: begin
                e.ctrl.aluSrcA = srcAReg;
                e.ctrl.aluSrcB = srcBReg;
                e.next = sAluWb;
            end
            sIExec: begin
                e.ctrl.aluSrcA = srcAReg;
                e.ctrl.aluSrcB = srcBImm;
                e.next = sAluWb;
            end
            sAluWb: e.ctrl.regWrite = 1'b1;
            sMemAddr: begin
                e.ctrl.aluSrcA = srcAReg;
                e.ctrl.aluSrcB = srcBImm;
                e.nextSel = nextDispatchMem;
            end
            sMemRead: begin
                e.ctrl.iOrD = 1'b1;
                e.ctrl.memRead = 1'b1;
                e.next = sLoadWb;
            end
            sLoadWb: begin
                e.ctrl.regWrite = 1'b1;
                e.ctrl.memToReg = 1'b1;
            end
            sMemWrite: begin
                e.ctrl.iOrD = 1'b1;
                e.ctrl.memWrite = 1'b1;
            end
            sBranch: begin
                e.ctrl.aluSrcA = srcAReg;
                e.ctrl.aluSrcB = srcBReg;
                e.ctrl.pcWriteCond = 1'b1;
                e.ctrl.pcSource = 1'b1;
            end
            sHalt: begin
                e.ctrl.isEcall = 1'b1;   // Parks here until reset
                e.next = sHalt;
            end
            default: e.next = sFetch;
        endcase
        return e;
    endfunction

    for (genvar i = 0; i < 16; i++) begin : gRom
        assign microRom[i] = romEntry(uState_t'(i));
    end

    // Dispatch table after decode
    always_comb begin
        case (opcode)
            opRType:         dispatchOp = sRExec;
            opIType:         dispatchOp = sIExec;
            opLoad, opStore: dispatchOp = sMemAddr;
            opBranch:        dispatchOp = sBranch;
            opSystem:        dispatchOp = sHalt;
            default:         dispatchOp = sFetch;   // Unknown opcode is a no-op
        endcase
    end

    assign dispatchMem = (opcode == opStore) ? sMemWrite : sMemRead;

    assign entry = microRom[state];
    assign ctrl = entry.ctrl;
    assign halted = entry.ctrl.isEcall;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sFetch;
        end else begin
            case (entry.nextSel)
                nextDispatchOp:  state <= dispatchOp;
                nextDispatchMem: state <= dispatchMem;
                default:         state <= entry.next;
            endcase
        end
    end

endmodule

// ==== aluExec.sv ====
`timescale 1ns/1ns

module aluExec (
    input  logic [rvPkg::xlen-1:0] pc,
    input  logic [rvPkg::xlen-1:0] regA,
    input  logic [rvPkg::xlen-1:0] regB,
    input  logic [rvPkg::xlen-1:0] imm,
    input  rvPkg::aluSrcA_t        srcA,
    input  rvPkg::aluSrcB_t        srcB,
    input  rvPkg::aluOp_t          op,
    output logic [rvPkg::xlen-1:0] result,
    output logic                   zero
);
    import rvPkg::*;

    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;

    always_comb begin
        opA = (srcA == srcAPc) ? pc : regA;
        case (srcB)
            srcBReg:  opB = regB;
            srcBFour: opB = xlen'(4);
            default:  opB = imm;
        endcase
        case (op)
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            default: result = opA + opB;
        endcase
    end

    assign zero = (result == '0);   // Equal operands on sub

endmodule

// ==== instrDecode.sv ====
`timescale 1ns/1ns

module instrDecode (
    input  rvPkg::instr_t            instr,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    output logic [4:0]               rd,
    output logic [rvPkg::xlen-1:0]   imm,
    output rvPkg::aluOp_t            aluOp
);
    import rvPkg::*;

    always_comb begin
        // Register fields sit at the same bits in every format
        rs1 = instr.r.rs1;
        rs2 = instr.r.rs2;
        rd = instr.r.rd;
        imm = {{(xlen - 12){instr.i.imm[11]}}, instr.i.imm};
        aluOp = aluAdd;
        case (instr.r.opcode)
            opRType: begin
                case (instr.r.funct3)
                    funct3AddSub: aluOp = (instr.r.funct7 == funct7Sub) ? aluSub : aluAdd;
                    funct3And:    aluOp = aluAnd;
                    funct3Or:     aluOp = aluOr;
                    default:      aluOp = aluAdd;
                endcase
            end
            opStore: begin
                imm = {{(xlen - 12){instr.s.immHigh[6]}}, instr.s.immHigh, instr.s.immLow};
            end
            opBranch: begin
                imm = {{(xlen - 12){instr.b.immSign}}, instr.b.immBit11,
                       instr.b.immMid, instr.b.immLow, 1'b0};
                aluOp = aluSub;   // Compare by subtraction
            end
            default: ;
        endcase
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  logic [4:0]             rd,
    input  logic                   writeEn,
    input  logic [rvPkg::xlen-1:0] writeData,
    output logic [rvPkg::xlen-1:0] readA,
    output logic [rvPkg::xlen-1:0] readB
);
    import rvPkg::*;

    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rd != 5'd0) begin
            // x0 never written, so it reads zero
            regs[rd] <= writeData;
        end
    end

    assign readA = regs[rs1];
    assign readB = regs[rs2];

endmodule

// ==== rvPkg.sv ====
package rvPkg;

    localparam int xlen = 32;

    // Base opcodes of the supported instructions
    localparam logic [6:0] opRType  = 7'b0110011;
    localparam logic [6:0] opIType  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opSystem = 7'b1110011;

    localparam logic [2:0] funct3AddSub = 3'b000;
    localparam logic [2:0] funct3Or     = 3'b110;
    localparam logic [2:0] funct3And    = 3'b111;
    localparam logic [6:0] funct7Sub    = 7'b0100000;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOp_t;
    typedef enum logic {srcAPc, srcAReg} aluSrcA_t;
    typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm} aluSrcB_t;

    typedef enum logic [3:0] {
        sFetch, sDecode, sRExec, sIExec, sAluWb, sMemAddr,
        sMemRead, sLoadWb, sMemWrite, sBranch, sHalt
    } uState_t;

    // 13-bit microcode control word
    typedef struct packed {
        logic     pcWriteCond;
        logic     pcWrite;
        logic     iOrD;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     irWrite;
        logic     pcSource;    // 0 ALU result, 1 ALUOut
        aluSrcB_t aluSrcB;
        aluSrcA_t aluSrcA;
        logic     regWrite;
        logic     isEcall;
    } ctrlWord_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmt_t;

    typedef struct packed {
        logic [6:0] immHigh;   // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLow;    // imm[4:0]
        logic [6:0] opcode;
    } sFmt_t;

    typedef struct packed {
        logic       immSign;   // imm[12]
        logic [5:0] immMid;    // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLow;    // imm[4:1]
        logic       immBit11;
        logic [6:0] opcode;
    } bFmt_t;

    typedef union packed {
        rFmt_t r;
        iFmt_t i;
        sFmt_t s;
        bFmt_t b;
    } instr_t;

endpackage
